//--- asg_pkg.sv
package asg_pkg;

  //////////////////////////////////////////////////
  // events
  //////////////////////////////////////////////////

  // one strobe per event, each high for one cycle
  typedef struct packed {
    // soft clear of engine and table pipeline
    logic rst;
    // arm the engine
    logic str;
    // stop after the current transfer
    logic stp;
    // software trigger
    logic swt;
  } evn_t;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // pointer integer part, also the table address width
  localparam int unsigned CWM = 8;
  // pointer fraction part
  localparam int unsigned CWF = 8;
  // burst period length counter
  localparam int unsigned CWL = 16;
  // burst period number counter
  localparam int unsigned CWN = 8;
  // sample width
  localparam int unsigned DW  = 14;

  // fixed point table pointer, integer bits on top
  typedef logic [CWM+CWF-1:0] ptr_t;

  // table address
  typedef logic [CWM-1:0] adr_t;

endpackage

//--- addr_stream_if.sv
`timescale 1ns/10ps

// table address stream between an engine and the table
interface addr_stream_if import asg_pkg::*; #(
  parameter int unsigned AW = CWM
) ();

  // source has a valid address
  logic          valid;
  // sink accepts it
  logic          ready;
  // table address
  logic [AW-1:0] adr;
  // final address of a sequence
  logic          last;

  // engine side
  modport src (
    output valid,
    output adr,
    output last,
    input  ready
  );

  // table side
  modport snk (
    input  valid,
    input  adr,
    input  last,
    output ready
  );

endinterface

//--- asg_per.sv
`timescale 1ns/10ps

// periodic address engine with a fixed point phase accumulator
module asg_per import asg_pkg::*; #(
  parameter int unsigned CWM = asg_pkg::CWM,
  parameter int unsigned CWF = asg_pkg::CWF
) (
  input  logic               sto,
  input  logic               reset,
  input  evn_t               evn,
  input  logic               trg,
  // table size, step and start offset in fixed point
  input  logic [CWM+CWF-1:0] cfg_siz,
  input  logic [CWM+CWF-1:0] cfg_ste,
  input  logic [CWM+CWF-1:0] cfg_off,
  output logic               run,
  addr_stream_if.src         str
);

  localparam int unsigned PW = CWM + CWF;

  logic          arm;
  logic          stp_pnd;
  logic [PW-1:0] ptr;
  // one extra bit so the sum never overflows
  logic [PW:0]   ptr_sum;
  logic [PW-1:0] ptr_nxt;
  logic          xfer;
  logic          hit;

  assign xfer = str.valid & str.ready;

  // trigger is only taken when armed and idle
  assign hit = arm & ~run & (evn.swt | trg);

  //////////////////////////////////////////////////
  // pointer
  //////////////////////////////////////////////////

  assign ptr_sum = {1'b0, ptr} + {1'b0, cfg_ste};
  // wrap modulo table size
  assign ptr_nxt = (ptr_sum >= {1'b0, cfg_siz}) ?
                   PW'(ptr_sum - {1'b0, cfg_siz}) : ptr_sum[PW-1:0];

  always_ff @(posedge sto) begin
    if (hit) begin
      ptr <= cfg_off;
    end else if (xfer) begin
      ptr <= ptr_nxt;
    end
  end

  // integer part addresses the table
  assign str.adr  = ptr[PW-1 -: CWM];
  // periodic mode never ends by itself
  assign str.last = 1'b0;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (reset || evn.rst) begin
      arm       <= 1'b0;
      run       <= 1'b0;
      stp_pnd   <= 1'b0;
      str.valid <= 1'b0;
    end else begin
      if (evn.str) begin
        arm <= 1'b1;
      end
      if (hit) begin
        arm       <= 1'b0;
        run       <= 1'b1;
        str.valid <= 1'b1;
      end else if (evn.stp || stp_pnd) begin
        arm <= 1'b0;
        // a pending address must still be taken
        if (!str.valid || xfer) begin
          str.valid <= 1'b0;
          run       <= 1'b0;
          stp_pnd   <= 1'b0;
        end else begin
          stp_pnd <= 1'b1;
        end
      end
    end
  end

  // offset and step must keep the pointer inside the table
  a_ptr_range: assert property (@(posedge sto) disable iff (reset)
    str.valid |-> ptr < cfg_siz);

  // address held across back-pressure
  a_adr_hold: assert property (@(posedge sto) disable iff (reset)
    str.valid && !str.ready && !evn.rst |=> str.valid && $stable(str.adr));

endmodule

//--- asg_bst.sv
`timescale 1ns/10ps

// burst address engine, periods of table addresses 0 to cfg_bdl-1
module asg_bst import asg_pkg::*; #(
  parameter int unsigned CWM = asg_pkg::CWM,
  parameter int unsigned CWL = asg_pkg::CWL,
  parameter int unsigned CWN = asg_pkg::CWN
) (
  input  logic           sto,
  input  logic           reset,
  input  evn_t           evn,
  input  logic           trg,
  // endless sequence
  input  logic           cfg_inf,
  // addresses per period
  input  logic [CWM-1:0] cfg_bdl,
  // minimum period length in cycles
  input  logic [CWL-1:0] cfg_bpl,
  // periods per sequence
  input  logic [CWN-1:0] cfg_bpn,
  output logic           run,
  output logic           evo_per,
  output logic [CWN-1:0] sts_bpn,
  addr_stream_if.src     str
);

  logic           arm;
  logic           stp_pnd;
  // cycles since period start, saturates at cfg_bpl
  logic [CWL-1:0] pcnt;
  logic [CWM-1:0] adr_lst;
  logic [CWN-1:0] bpn_lst;
  logic           xfer;
  logic           hit;
  logic           per_end;
  logic           nxt_per;

  assign xfer    = str.valid & str.ready;
  assign hit     = arm & ~run & (evn.swt | trg);
  assign adr_lst = cfg_bdl - 1'b1;
  assign bpn_lst = cfg_bpn - 1'b1;

  // final address of a period is taken
  assign per_end = xfer & (str.adr == adr_lst);

  // next period once data is out and period length is met
  assign nxt_per = run & ~str.valid & (pcnt >= cfg_bpl) & ~stp_pnd & ~evn.stp;

  // final address of the final period
  assign str.last = ~cfg_inf & (str.adr == adr_lst) & (sts_bpn == bpn_lst);

  //////////////////////////////////////////////////
  // data address
  //////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (hit || nxt_per) begin
      str.adr <= '0;
    end else if (xfer) begin
      str.adr <= str.adr + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // period and sequence control
  //////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (reset || evn.rst) begin
      arm       <= 1'b0;
      run       <= 1'b0;
      stp_pnd   <= 1'b0;
      evo_per   <= 1'b0;
      pcnt      <= '0;
      sts_bpn   <= '0;
      str.valid <= 1'b0;
    end else begin
      // strobe lines up with the first valid of a period
      evo_per <= hit | nxt_per;
      if (evn.str) begin
        arm <= 1'b1;
      end
      // period length counter
      if (hit || nxt_per) begin
        pcnt <= CWL'(1);
      end else if (pcnt < cfg_bpl) begin
        pcnt <= pcnt + 1'b1;
      end
      // completed periods
      if (per_end) begin
        sts_bpn <= sts_bpn + 1'b1;
      end
      if (hit) begin
        arm       <= 1'b0;
        run       <= 1'b1;
        sts_bpn   <= '0;
        str.valid <= 1'b1;
      end else if (evn.stp || stp_pnd) begin
        arm <= 1'b0;
        if (!str.valid || xfer) begin
          str.valid <= 1'b0;
          run       <= 1'b0;
          stp_pnd   <= 1'b0;
        end else begin
          stp_pnd <= 1'b1;
        end
      end else if (nxt_per) begin
        str.valid <= 1'b1;
      end else if (per_end) begin
        // wait for the period length
        str.valid <= 1'b0;
        if (str.last) begin
          run <= 1'b0;
        end
      end
    end
  end

  // last only in a finite burst, and the engine goes idle after it
  a_last_end: assert property (@(posedge sto) disable iff (reset || evn.rst)
    str.valid && str.ready && str.last |-> !cfg_inf ##1 !run && !str.valid);

endmodule

//--- asg_table.sv
`timescale 1ns/10ps

// stream select, table RAM and read pipeline
module asg_table import asg_pkg::*; #(
  parameter int unsigned CWM = asg_pkg::CWM,
  parameter int unsigned DW  = asg_pkg::DW
) (
  input  logic           sto,
  input  logic           reset,
  // burst stream when set, periodic otherwise
  input  logic           cfg_ben,
  input  logic           evn_rst,
  // host write port
  input  logic           wen,
  input  logic [CWM-1:0] waddr,
  input  logic [DW-1:0]  wdata,
  addr_stream_if.snk     str_per,
  addr_stream_if.snk     str_bst,
  output logic           out_valid,
  input  logic           out_ready,
  output logic [DW-1:0]  out_data,
  output logic           out_last,
  output logic           evo_lst
);

  // table
  logic [DW-1:0]  mem [0:2**CWM-1];

  // selected address stream
  logic           sel_valid;
  logic [CWM-1:0] sel_adr;
  logic           sel_last;

  // pipeline
  logic           adv;
  logic [CWM-1:0] adr_reg;
  logic [DW-1:0]  rdata;
  logic [1:0]     vld;
  logic [1:0]     lst;

  //////////////////////////////////////////////////
  // mode select
  //////////////////////////////////////////////////

  assign sel_valid = cfg_ben ? str_bst.valid : str_per.valid;
  assign sel_adr   = cfg_ben ? str_bst.adr   : str_per.adr;
  assign sel_last  = cfg_ben ? str_bst.last  : str_per.last;

  // all stages move together when the output slot is empty or taken
  assign adv = out_ready | ~out_valid;

  // unselected engine is never acknowledged
  assign str_per.ready = ~cfg_ben & adv;
  assign str_bst.ready =  cfg_ben & adv;

  //////////////////////////////////////////////////
  // table RAM
  //////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  // stage 0 address, stage 1 read data
  always_ff @(posedge sto) begin
    if (adv) begin
      adr_reg <= sel_adr;
      rdata   <= mem[adr_reg];
    end
  end

  //////////////////////////////////////////////////
  // valid and last shift registers
  //////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (reset || evn_rst) begin
      vld <= 2'b00;
      lst <= 2'b00;
    end else if (adv) begin
      vld <= {vld[0], sel_valid};
      lst <= {lst[0], sel_valid & sel_last};
    end
  end

  //////////////////////////////////////////////////
  // output stream
  //////////////////////////////////////////////////

  assign out_valid = vld[1];
  assign out_last  = lst[1];
  assign out_data  = rdata;

  // pulse when the final sample leaves
  assign evo_lst = out_valid & out_ready & out_last;

  // sample held through a stall
  a_data_hold: assert property (@(posedge sto) disable iff (reset)
    out_valid && !out_ready && !evn_rst |=> out_valid && $stable(out_data));

endmodule

//--- asg_top.sv
`timescale 1ns/10ps

// one generator channel
module asg_top import asg_pkg::*; #(
  parameter int unsigned CWM = asg_pkg::CWM,
  parameter int unsigned CWF = asg_pkg::CWF,
  parameter int unsigned CWL = asg_pkg::CWL,
  parameter int unsigned CWN = asg_pkg::CWN,
  parameter int unsigned DW  = asg_pkg::DW
) (
  input  logic               sto,
  input  logic               reset,
  // events
  input  logic               evn_rst,
  input  logic               evn_str,
  input  logic               evn_stp,
  input  logic               evn_swt,
  input  logic               trg,
  // mode
  input  logic               cfg_ben,
  input  logic               cfg_inf,
  input  logic               cfg_trg_en,
  // periodic
  input  logic [CWM+CWF-1:0] cfg_siz,
  input  logic [CWM+CWF-1:0] cfg_ste,
  input  logic [CWM+CWF-1:0] cfg_off,
  // burst
  input  logic [CWM-1:0]     cfg_bdl,
  input  logic [CWL-1:0]     cfg_bpl,
  input  logic [CWN-1:0]     cfg_bpn,
  // table write
  input  logic               wen,
  input  logic [CWM-1:0]     waddr,
  input  logic [DW-1:0]      wdata,
  // sample stream
  output logic               out_valid,
  input  logic               out_ready,
  output logic [DW-1:0]      out_data,
  output logic               out_last,
  // status
  output logic               run,
  output logic               evo_per,
  output logic               evo_lst,
  output logic [CWN-1:0]     sts_bpn
);

  evn_t evn;
  evn_t evn_per;
  evn_t evn_bst;
  logic trg_en;
  logic run_per;
  logic run_bst;

  addr_stream_if #(.AW (CWM)) str_per ();
  addr_stream_if #(.AW (CWM)) str_bst ();

  //////////////////////////////////////////////////
  // event routing
  //////////////////////////////////////////////////

  assign evn = '{rst: evn_rst, str: evn_str, stp: evn_stp, swt: evn_swt};

  // idle engine sees no events
  assign evn_per = cfg_ben ? '0  : evn;
  assign evn_bst = cfg_ben ? evn : '0;

  // hardware trigger only when enabled
  assign trg_en = trg & cfg_trg_en;

  assign run = cfg_ben ? run_bst : run_per;

  //////////////////////////////////////////////////
  // engines and table
  //////////////////////////////////////////////////

  asg_per #(.CWM (CWM), .CWF (CWF)) asg_per_inst (
    .sto (sto), .reset (reset), .evn (evn_per), .trg (trg_en & ~cfg_ben),
    .cfg_siz (cfg_siz), .cfg_ste (cfg_ste), .cfg_off (cfg_off),
    .run (run_per), .str (str_per)
  );

  asg_bst #(.CWM (CWM), .CWL (CWL), .CWN (CWN)) asg_bst_inst (
    .sto (sto), .reset (reset), .evn (evn_bst), .trg (trg_en & cfg_ben),
    .cfg_inf (cfg_inf), .cfg_bdl (cfg_bdl), .cfg_bpl (cfg_bpl), .cfg_bpn (cfg_bpn),
    .run (run_bst), .evo_per (evo_per), .sts_bpn (sts_bpn), .str (str_bst)
  );

  asg_table #(.CWM (CWM), .DW (DW)) asg_table_inst (
    .sto (sto), .reset (reset), .cfg_ben (cfg_ben), .evn_rst (evn_rst),
    .wen (wen), .waddr (waddr), .wdata (wdata),
    .str_per (str_per), .str_bst (str_bst),
    .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data),
    .out_last (out_last), .evo_lst (evo_lst)
  );

endmodule

//--- tb_clock.sv
`timescale 1ns/10ps

// free running clock for the testbench
module tb_clock #(
  // period in ns
  parameter int unsigned PERIOD = 10
) (
  output logic sto
);

  // starts low so the first rising edge is half a period in
  initial begin
    sto = 1'b0;
  end

  always begin
    #(PERIOD / 2.0);
    sto = ~sto;
  end

endmodule

//--- tb_asg.sv
`timescale 1ns/10ps

// testbench for one generator channel
module tb_asg import asg_pkg::*; ();

  // dut inputs
  logic               sto;
  logic               reset;
  logic               evn_rst;
  logic               evn_str;
  logic               evn_stp;
  logic               evn_swt;
  logic               trg;
  logic               cfg_ben;
  logic               cfg_inf;
  logic               cfg_trg_en;
  logic [CWM+CWF-1:0] cfg_siz;
  logic [CWM+CWF-1:0] cfg_ste;
  logic [CWM+CWF-1:0] cfg_off;
  logic [CWM-1:0]     cfg_bdl;
  logic [CWL-1:0]     cfg_bpl;
  logic [CWN-1:0]     cfg_bpn;
  logic               wen;
  logic [CWM-1:0]     waddr;
  logic [DW-1:0]      wdata;
  logic               out_ready;
  // dut outputs
  logic               out_valid;
  logic [DW-1:0]      out_data;
  logic               out_last;
  logic               run;
  logic               evo_per;
  logic               evo_lst;
  logic [CWN-1:0]     sts_bpn;

  // table copy and model state
  logic [DW-1:0]      ref_mem [0:2**CWM-1];
  int                 m_ptr;
  int                 m_k;
  int                 got;
  int                 per_cnt;
  int                 exp_adr;
  logic               exp_last;
  logic               held;
  logic [DW-1:0]      held_data;
  // record fields and run control
  int                 fld [0:8];
  int                 exp_cnt;
  logic               bp_mode;
  logic [31:0]        lfsr;
  int                 cycles;
  int                 limit;

  tb_clock #(.PERIOD (10)) tb_clock_inst (.sto (sto));

  asg_top asg_top_inst (
    .sto (sto), .reset (reset),
    .evn_rst (evn_rst), .evn_str (evn_str), .evn_stp (evn_stp), .evn_swt (evn_swt),
    .trg (trg), .cfg_ben (cfg_ben), .cfg_inf (cfg_inf), .cfg_trg_en (cfg_trg_en),
    .cfg_siz (cfg_siz), .cfg_ste (cfg_ste), .cfg_off (cfg_off),
    .cfg_bdl (cfg_bdl), .cfg_bpl (cfg_bpl), .cfg_bpn (cfg_bpn),
    .wen (wen), .waddr (waddr), .wdata (wdata),
    .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data),
    .out_last (out_last), .run (run), .evo_per (evo_per), .evo_lst (evo_lst),
    .sts_bpn (sts_bpn)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED at %0t: %s expected %0h actual %0h", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // next record from the vector file, kind is its tag or -1 at end
  task automatic read_record(input int fd, output int kind);
    int c;
    int n;
    kind = 0;
    while (kind == 0) begin
      c = $fgetc(fd);
      if (c == -1) begin
        kind = -1;
      end else if (c == "#") begin
        // comment up to end of line
        while (c != "\n" && c != -1) begin
          c = $fgetc(fd);
        end
      end else if (c == "w" || c == "t") begin
        n = $fscanf(fd, " %h %h", fld[0], fld[1]);
        kind = (n == 2) ? c : -2;
      end else if (c == "n") begin
        n = $fscanf(fd, " %h", fld[0]);
        kind = (n == 1) ? c : -2;
      end else if (c == "c") begin
        n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                    fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
        kind = (n == 9) ? c : -2;
      end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
        kind = -2;
      end
    end
    if (kind == -2) begin
      $display("malformed record in asg_vectors.txt");
      $display("Simulation failed");
      $fatal(1, "bad vector file");
    end
  endtask

  // one table word, mirrored into the reference copy
  task automatic write_word(input int a, input int d);
    @(negedge sto);
    wen   = 1'b1;
    waddr = adr_t'(a);
    wdata = DW'(d);
    ref_mem[a] = DW'(d);
    @(negedge sto);
    wen = 1'b0;
  endtask

  task automatic set_config();
    @(negedge sto);
    cfg_ben = fld[0] != 0;
    cfg_inf = fld[1] != 0;
    bp_mode = fld[2] != 0;
    cfg_siz = ptr_t'(fld[3]);
    cfg_ste = ptr_t'(fld[4]);
    cfg_off = ptr_t'(fld[5]);
    cfg_bdl = adr_t'(fld[6]);
    cfg_bpl = CWL'(fld[7]);
    cfg_bpn = CWN'(fld[8]);
  endtask

  // model back to the start of a sequence
  task automatic restart_model();
    m_ptr   = cfg_off;
    m_k     = 0;
    got     = 0;
    per_cnt = 0;
    held    = 1'b0;
  endtask

  // src 1 uses the trg pin, act 0 natural end, 1 stop, 2 soft reset and rerun
  task automatic run_test(input int src, input int act);
    int pass;
    int idle;
    int got_stop;
    for (pass = 0; pass < ((act == 2) ? 2 : 1); pass++) begin
      restart_model();
      @(negedge sto);
      evn_str = 1'b1;
      @(negedge sto);
      evn_str = 1'b0;
      if (src != 0) begin
        trg = 1'b1;
      end else begin
        evn_swt = 1'b1;
      end
      @(negedge sto);
      trg     = 1'b0;
      evn_swt = 1'b0;
      check("run after trigger", 1, run);
      while (got < exp_cnt) begin
        @(negedge sto);
      end
      if (act == 2 && pass == 0) begin
        // clear in the middle of the stream
        evn_rst = 1'b1;
        @(negedge sto);
        evn_rst = 1'b0;
        check("out_valid after evn_rst", 0, out_valid);
        check("run after evn_rst", 0, run);
      end
    end
    if (act == 0) begin
      while (run) begin
        @(negedge sto);
      end
      repeat (4) @(negedge sto);
      check("sample count", exp_cnt, got);
      check("sts_bpn", cfg_bpn, sts_bpn);
      check("evo_per count", cfg_bpn, per_cnt);
    end else begin
      evn_stp = 1'b1;
      @(negedge sto);
      evn_stp = 1'b0;
      // in flight samples drain first
      idle = 0;
      while (idle < 3) begin
        @(negedge sto);
        idle = (run || out_valid) ? 0 : idle + 1;
      end
      got_stop = got;
      repeat (8) @(negedge sto);
      check("samples after stop", got_stop, got);
    end
    check("run at end", 0, run);
  endtask

  //////////////////////////////////////////////////
  // ready pattern, monitor, watchdog
  //////////////////////////////////////////////////

  always @(negedge sto) begin
    if (bp_mode) begin
      lfsr      = lfsr_next(lfsr);
      out_ready = lfsr[0];
    end else begin
      out_ready = 1'b1;
    end
  end

  always @(posedge sto) begin
    if (!reset) begin
      // stalled sample stays put
      if (held && out_valid) begin
        check("out_data hold", held_data, out_data);
      end
      held      = out_valid && !out_ready;
      held_data = out_data;
      if (out_valid && out_ready) begin
        if (cfg_ben) begin
          // addresses 0 to bdl-1 in every period
          exp_adr  = m_k % int'(cfg_bdl);
          exp_last = !cfg_inf && (m_k == int'(cfg_bdl) * int'(cfg_bpn) - 1);
        end else begin
          // integer part of the phase, then step and wrap
          exp_adr  = m_ptr >> CWF;
          exp_last = 1'b0;
          m_ptr    = m_ptr + int'(cfg_ste);
          if (m_ptr >= int'(cfg_siz)) begin
            m_ptr = m_ptr - int'(cfg_siz);
          end
        end
        check("out_data", ref_mem[exp_adr], out_data);
        check("out_last", exp_last, out_last);
        check("evo_lst", exp_last, evo_lst);
        m_k = m_k + 1;
        got = got + 1;
      end
      if (evo_per) begin
        per_cnt = per_cnt + 1;
      end
    end
  end

  always @(posedge sto) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout, DUT gave no result within %0d cycles", limit);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin : main
    int fd;
    int kind;
    int sum;
    reset      = 1'b1;
    evn_rst    = 1'b0;
    evn_str    = 1'b0;
    evn_stp    = 1'b0;
    evn_swt    = 1'b0;
    trg        = 1'b0;
    cfg_ben    = 1'b0;
    cfg_inf    = 1'b0;
    cfg_trg_en = 1'b1;
    cfg_siz    = '0;
    cfg_ste    = '0;
    cfg_off    = '0;
    cfg_bdl    = '0;
    cfg_bpl    = '0;
    cfg_bpn    = '0;
    wen        = 1'b0;
    waddr      = '0;
    wdata      = '0;
    out_ready  = 1'b1;
    bp_mode    = 1'b0;
    lfsr       = 32'h19f7a3b9;
    cycles     = 0;
    limit      = 0;
    exp_cnt    = 0;
    restart_model();
    // first pass sizes the watchdog
    fd = $fopen("asg_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open asg_vectors.txt");
      $display("Simulation failed");
      $fatal(1, "vector file missing");
    end
    sum = 0;
    read_record(fd, kind);
    while (kind != -1) begin
      case (kind)
        "w": sum += 2;
        "c": sum += fld[7] * fld[8] + 20;
        "n": sum += 2 * fld[0];
        default: sum += 30;
      endcase
      read_record(fd, kind);
    end
    $fclose(fd);
    limit = 4 * sum + 20;
    repeat (4) @(posedge sto);
    @(negedge sto);
    reset = 1'b0;
    check("out_valid after reset", 0, out_valid);
    check("run after reset", 0, run);
    check("evo_per after reset", 0, evo_per);
    check("evo_lst after reset", 0, evo_lst);
    // second pass runs the records in order
    fd = $fopen("asg_vectors.txt", "r");
    read_record(fd, kind);
    while (kind != -1) begin
      case (kind)
        "w": write_word(fld[0], fld[1]);
        "c": set_config();
        "n": exp_cnt = fld[0];
        default: run_test(fld[0], fld[1]);
      endcase
      read_record(fd, kind);
    end
    $fclose(fd);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- asg_vectors.txt
# w addr data | c ben inf bp siz ste off bdl bpl bpn | n count | t src act
# all hex; bp 1 random out_ready; src 1 trg pin; act 0 burst end, 1 stop, 2 soft reset
w 00 0123
w 01 3a5c
w 02 1f00
w 03 0abc
w 04 2d2d
w 05 3fff
w 06 0001
w 07 1357
# periodic, integer step, several wraps
c 0 0 0 0800 0300 0200 00 0000 00
n 18
t 0 1
# periodic, fractional step with repeats
c 0 0 0 0500 00c0 0040 00 0000 00
n 14
t 1 1
# finite burst
c 1 0 0 0000 0000 0000 05 000c 04
n 14
t 0 0
# periodic under back-pressure
c 0 0 1 0800 0300 0200 00 0000 00
n 18
t 0 1
# finite burst under back-pressure
c 1 0 1 0000 0000 0000 07 0003 03
n 15
t 0 0
# endless burst, then stop
c 1 1 0 0000 0000 0000 06 0008 02
n 14
t 0 1
# soft reset mid stream, rerun from the start
c 0 0 1 0800 0280 0100 00 0000 00
n 0c
t 0 2

//--- compile.f
asg_pkg.sv
addr_stream_if.sv
asg_per.sv
asg_bst.sv
asg_table.sv
asg_top.sv
tb_clock.sv
tb_asg.sv

//--- Bender.yml
package:
  name: asg

sources:
  - asg_pkg.sv
  - addr_stream_if.sv
  - asg_per.sv
  - asg_bst.sv
  - asg_table.sv
  - asg_top.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_asg.sv
